/* all.f */
rtl/rvCorePkg.sv
rtl/instrDecode.sv
rtl/aluExecute.sv
rtl/loadStoreUnit.sv
rtl/regFileWriteback.sv
rtl/rvCore.sv
tests/tbClock.sv
tests/rvCoreTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module rvCoreTb -f all.f -o rvCoreSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/rvCoreSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1

/* tests/rvCoreTb.sv */
module rvCoreTb;
	import rvCorePkg::*;

	localparam int codeJalr = 'b1100111;
	localparam int codeLoad = 'b0000011;
	localparam int codeOpImm = 'b0010011;
	localparam int dataOffset = 'h40;
	localparam int resultOffset = 'h80;
	localparam int caseCycles = 150;
	localparam word_t dataWord = 32'hF08A7C85;
	localparam word_t spin = 32'h0000006F;

	typedef struct packed {
		word_t [7:0] words;
		errorCode_e expectError;
		word_t expectData;
		word_t faultPc;
	} testCase_t;

	logic clk;
	logic rst;
	logic run;
	logic caseReset;
	logic memoryBusy = 1'b0;
	word_t memoryDataRead;
	memRequest_t memoryRequest;
	errorCode_e errorCode;
	word_t programCounter;

	word_t memory [64];
	word_t image [64];
	logic storeSeen;
	word_t storeData;
	logic [3:0] storeMask;
	testCase_t caseTable [$];
	word_t draft [8];
	int draftLength;
	int caseCount = 0;
	int errors;
	int seed = 32'h662f;

	tbClock clockGen (
		.clk(clk),
		.rst(rst)
	);

	rvCore #(
		.resetVector(32'h0)
	) uut (
		.clk(clk),
		.rst(rst || caseReset),
		.run(run),
		.memoryDataRead(memoryDataRead),
		.memoryBusy(memoryBusy),
		.memoryRequest(memoryRequest),
		.errorCode(errorCode),
		.programCounter(programCounter)
	);

	// Word-addressed memory reloaded from the image during reset
	assign memoryDataRead = memory[memoryRequest.address[7:2]];

	always @(posedge clk) begin
		if (caseReset) begin
			for (int i = 0; i < 64; i++) memory[i] <= image[i];
			storeSeen <= 1'b0;
		end else if (memoryRequest.writeEnable && !memoryBusy) begin
			for (int b = 0; b < 4; b++) begin
				if (memoryRequest.byteSelect[b]) begin
					memory[memoryRequest.address[7:2]][b * 8 +: 8] <=
						memoryRequest.writeData[b * 8 +: 8];
				end
			end
			if (memoryRequest.address == resultOffset && !storeSeen) begin
				storeSeen <= 1'b1;
				storeData <= memoryRequest.writeData;
				storeMask <= memoryRequest.byteSelect;
			end
		end
	end

	// Roughly one busy cycle in four
	always @(negedge clk) begin
		memoryBusy <= ($random(seed) & 3) == 0;
	end

	function automatic word_t rType(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic word_t iType(int imm, int rs1, int f3, int rd, int op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic word_t sType(int imm, int rs2, int rs1, int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t bType(int imm, int rs2, int rs1, int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t uType(int upper, int rd);
		return {upper[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic word_t jType(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic word_t storeResult(int rs2);
		return sType(resultOffset, rs2, 0, 2);
	endfunction

	function automatic word_t patternWord(int i);
		return 32'h9E3779B1 * word_t'(i + 1);
	endfunction

	function automatic word_t mergeBytes(word_t old, word_t value, int offset, int size);
		word_t result;
		result = old;
		for (int j = 0; j < size; j++) result[(offset + j) * 8 +: 8] = value[j * 8 +: 8];
		return result;
	endfunction

	task automatic startDraft();
		for (int i = 0; i < 8; i++) draft[i] = spin;
		draftLength = 0;
	endtask

	task automatic emit(word_t w);
		draft[draftLength] = w;
		draftLength++;
	endtask

	task automatic addCase(errorCode_e err, word_t data, word_t pc);
		testCase_t tc;
		for (int i = 0; i < 8; i++) tc.words[i] = draft[i];
		tc.expectError = err;
		tc.expectData = data;
		tc.faultPc = pc;
		caseTable.push_back(tc);
	endtask

	// x1 = -5, x2 = 300, result in x3
	task automatic registerOpCase(int f7, int f3, word_t expected);
		startDraft();
		emit(iType(-5, 0, 0, 1, codeOpImm));
		emit(iType(300, 0, 0, 2, codeOpImm));
		emit(rType(f7, 2, 1, f3, 3));
		emit(storeResult(3));
		addCase(errNone, expected, '0);
	endtask

	// x1 = 0x80000FF0, x2 = shift amount
	task automatic shiftCase(int amount, word_t opWord, word_t expected);
		startDraft();
		emit(uType('h80001, 1));
		emit(iType(-16, 1, 0, 1, codeOpImm));
		emit(iType(amount, 0, 0, 2, codeOpImm));
		emit(opWord);
		emit(storeResult(3));
		addCase(errNone, expected, '0);
	endtask

	task automatic loadCase(int f3, int offset, word_t expected);
		startDraft();
		emit(iType(dataOffset + offset, 0, f3, 3, codeLoad));
		emit(storeResult(3));
		addCase(errNone, expected, '0);
	endtask

	// Store 0x11223344 with the given size, then read the whole word back
	task automatic storeCase(int f3, int offset, int size);
		startDraft();
		emit(uType('h11223, 2));
		emit(iType('h344, 2, 0, 2, codeOpImm));
		emit(sType(dataOffset + offset, 2, 0, f3));
		emit(iType(dataOffset, 0, 2, 3, codeLoad));
		emit(storeResult(3));
		addCase(errNone, mergeBytes(dataWord, 32'h11223344, offset, size), '0);
	endtask

	task automatic buildTable();
		word_t a;
		word_t b;
		word_t v;
		word_t c;
		logic taken;
		int amounts [3];
		int branchCodes [6];
		a = 32'hFFFFFFFB;
		b = 32'd300;
		v = 32'h80001000 - 32'd16;
		amounts = '{0, 1, 31};
		branchCodes = '{0, 1, 4, 5, 6, 7};
		startDraft();
		emit(iType(-5, 0, 0, 1, codeOpImm));
		emit(iType(1000, 1, 0, 3, codeOpImm));
		emit(storeResult(3));
		addCase(errNone, a + 32'd1000, '0);
		startDraft();
		emit(uType('hABCDE, 3));
		emit(storeResult(3));
		addCase(errNone, 32'hABCDE << 12, '0);
		registerOpCase(0, 0, a + b);
		registerOpCase('h20, 0, a - b);
		registerOpCase(0, 2, {31'b0, $signed(a) < $signed(b)});
		registerOpCase(0, 3, {31'b0, a < b});
		registerOpCase(0, 4, a ^ b);
		registerOpCase(0, 6, a | b);
		registerOpCase(0, 7, a & b);
		foreach (amounts[n]) begin
			shiftCase(amounts[n], iType(amounts[n], 1, 1, 3, codeOpImm), v << amounts[n]);
			shiftCase(amounts[n], iType(amounts[n], 1, 5, 3, codeOpImm), v >> amounts[n]);
			shiftCase(amounts[n], iType('h400 | amounts[n], 1, 5, 3, codeOpImm),
				$signed(v) >>> amounts[n]);
			shiftCase(amounts[n], rType(0, 2, 1, 1, 3), v << amounts[n]);
		end
		// Branch on x1 = -5 against x2 = 7 with 0x22 stored on the taken path
		c = 32'd7;
		foreach (branchCodes[n]) begin
			case (branchCodes[n])
				0: taken = a == c;
				1: taken = a != c;
				4: taken = $signed(a) < $signed(c);
				5: taken = $signed(a) >= $signed(c);
				6: taken = a < c;
				default: taken = a >= c;
			endcase
			startDraft();
			emit(iType(-5, 0, 0, 1, codeOpImm));
			emit(iType(7, 0, 0, 2, codeOpImm));
			emit(bType(12, 2, 1, branchCodes[n]));
			emit(iType('h11, 0, 0, 3, codeOpImm));
			emit(storeResult(3));
			emit(iType('h22, 0, 0, 3, codeOpImm));
			emit(storeResult(3));
			addCase(errNone, taken ? 32'h22 : 32'h11, '0);
		end
		// JAL at 4 links 8
		startDraft();
		emit(iType('h33, 0, 0, 3, codeOpImm));
		emit(jType(12, 5));
		emit(storeResult(3));
		emit(spin);
		emit(storeResult(5));
		addCase(errNone, 32'd4 + 32'd4, '0);
		// JALR to 21 lands on 20
		startDraft();
		emit(iType(21, 0, 0, 6, codeOpImm));
		emit(iType(0, 6, 0, 5, codeJalr));
		emit(iType('h33, 0, 0, 3, codeOpImm));
		emit(storeResult(3));
		emit(spin);
		emit(storeResult(5));
		addCase(errNone, 32'd4 + 32'd4, '0);
		for (int k = 0; k < 4; k++) begin
			loadCase(0, k, {{24{dataWord[k * 8 + 7]}}, dataWord[k * 8 +: 8]});
			loadCase(4, k, {24'b0, dataWord[k * 8 +: 8]});
			storeCase(0, k, 1);
		end
		for (int k = 0; k < 3; k++) begin
			loadCase(1, k, {{16{dataWord[k * 8 + 15]}}, dataWord[k * 8 +: 16]});
			loadCase(5, k, {16'b0, dataWord[k * 8 +: 16]});
			storeCase(1, k, 2);
		end
		storeCase(2, 0, 4);
		startDraft();
		emit(iType(1, 0, 0, 1, codeOpImm));
		emit(32'h00000073);
		addCase(errInvalidInstruction, '0, 32'd4);
		startDraft();
		emit(32'h00000000);
		addCase(errInvalidInstruction, '0, 32'd0);
		startDraft();
		emit(iType(dataOffset, 0, 0, 1, codeOpImm));
		emit(iType(2, 1, 2, 3, codeLoad));
		addCase(errMisaligned, '0, 32'd4);
	endtask

	task automatic loadImage(testCase_t tc);
		for (int i = 0; i < 64; i++) image[i] = patternWord(i);
		image[dataOffset / 4] = dataWord;
		image[resultOffset / 4] = '0;
		for (int i = 0; i < 8; i++) image[i] = tc.words[i];
	endtask

	task automatic checkStore(int idx, testCase_t tc);
		assert (errorCode == errNone) else begin
			errors++;
			$display("[ERROR] case %0d errorCode: got %h, expected %h", idx, errorCode, errNone);
		end
		assert (storeData == tc.expectData) else begin
			errors++;
			$display("[ERROR] case %0d memoryRequest.writeData: got %h, expected %h",
				idx, storeData, tc.expectData);
		end
		assert (storeMask == 4'hF) else begin
			errors++;
			$display("[ERROR] case %0d memoryRequest.byteSelect: got %h, expected %h",
				idx, storeMask, 4'hF);
		end
	endtask

	task automatic checkFault(int idx, testCase_t tc);
		assert (errorCode == tc.expectError) else begin
			errors++;
			$display("[ERROR] case %0d errorCode: got %h, expected %h",
				idx, errorCode, tc.expectError);
		end
		// Frozen core must stay off the bus
		repeat (10) begin
			@(negedge clk);
			assert (!memoryRequest.readEnable && !memoryRequest.writeEnable) else begin
				errors++;
				$display("Case %0d: the core made a memory request after its fault", idx);
			end
		end
		assert (programCounter == tc.faultPc) else begin
			errors++;
			$display("[ERROR] case %0d programCounter: got %h, expected %h",
				idx, programCounter, tc.faultPc);
		end
	endtask

	task automatic runCase(int idx);
		testCase_t tc;
		logic finished;
		tc = caseTable[idx];
		loadImage(tc);
		@(negedge clk);
		run = 1'b0;
		caseReset = 1'b1;
		repeat (3) @(negedge clk);
		caseReset = 1'b0;
		@(negedge clk);
		run = 1'b1;
		finished = 1'b0;
		for (int c = 0; c < caseCycles && !finished; c++) begin
			@(negedge clk);
			finished = storeSeen || errorCode != errNone;
		end
		assert (finished) else begin
			errors++;
			$display("Case %0d neither stored a result nor faulted within %0d cycles",
				idx, caseCycles);
		end
		if (finished && tc.expectError == errNone) begin
			checkStore(idx, tc);
		end else if (finished) begin
			checkFault(idx, tc);
		end
	endtask

	initial begin
		wait (caseCount > 0);
		#(caseCount * 200 * 40);
		$display("Watchdog expired before all cases finished");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		run = 1'b0;
		caseReset = 1'b1;
		errors = 0;
		buildTable();
		caseCount = caseTable.size();
		wait (!rst);
		for (int i = 0; i < caseCount; i++) runCase(i);
		$display("Ran %0d cases with %0d error(s)", caseCount, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* tests/tbClock.sv */
module tbClock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Held over three rising edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

/* rtl/rvCore.sv */
module rvCore #(
	parameter rvCorePkg::word_t resetVector = '0
) (
	input logic clk,
	input logic rst,
	input logic run,
	input rvCorePkg::word_t memoryDataRead,
	input logic memoryBusy,
	output rvCorePkg::memRequest_t memoryRequest,
	output rvCorePkg::errorCode_e errorCode,
	output rvCorePkg::word_t programCounter
);
	import rvCorePkg::*;

	coreState_e state;
	word_t instruction;
	decodedInstr_t decoded;
	word_t rs1Value;
	word_t rs2Value;
	word_t aluResult;
	word_t sum;
	word_t linkAddress;
	word_t nextProgramCounter;
	word_t fetchedWord;
	word_t loadData;
	logic stepDone;
	logic misaligned;
	logic isMemoryOp;
	logic commit;

	instrDecode decoder (
		.instruction(instruction),
		.decoded(decoded)
	);

	aluExecute alu (
		.decoded(decoded),
		.rs1Value(rs1Value),
		.rs2Value(rs2Value),
		.programCounter(programCounter),
		.aluResult(aluResult),
		.sum(sum),
		.linkAddress(linkAddress),
		.nextProgramCounter(nextProgramCounter)
	);

	loadStoreUnit lsu (
		.state(state),
		.programCounter(programCounter),
		.address(sum),
		.decoded(decoded),
		.rs2Value(rs2Value),
		.memoryDataRead(memoryDataRead),
		.memoryBusy(memoryBusy),
		.memoryRequest(memoryRequest),
		.fetchedWord(fetchedWord),
		.loadData(loadData),
		.stepDone(stepDone),
		.misaligned(misaligned)
	);

	regFileWriteback regFile (
		.clk(clk),
		.decoded(decoded),
		.commit(commit),
		.aluResult(aluResult),
		.sum(sum),
		.linkAddress(linkAddress),
		.loadData(loadData),
		.rs1Value(rs1Value),
		.rs2Value(rs2Value)
	);

	assign isMemoryOp = decoded.opcode == opLoad || decoded.opcode == opStore;
	// Memory ops wait for the bus, everything else retires at once
	assign commit = state == stateExecute && decoded.valid && !misaligned &&
		(!isMemoryOp || stepDone);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateHalt;
			programCounter <= resetVector;
			errorCode <= errNone;
		end else begin
			case (state)
				stateHalt: begin
					// A recorded error keeps the core parked here
					if (run && errorCode == errNone) state <= stateFetch;
				end
				stateFetch: begin
					if (stepDone) state <= stateExecute;
				end
				stateExecute: begin
					if (!decoded.valid) begin
						errorCode <= errInvalidInstruction;
						state <= stateHalt;
					end else if (misaligned) begin
						errorCode <= errMisaligned;
						state <= stateHalt;
					end else if (commit) begin
						programCounter <= nextProgramCounter;
						state <= run ? stateFetch : stateHalt;
					end
				end
				default: state <= stateHalt;
			endcase
		end
	end

	// Instruction register
	always_ff @(posedge clk) begin
		if (state == stateFetch && stepDone) instruction <= fetchedWord;
	end

endmodule

/* rtl/regFileWriteback.sv */
module regFileWriteback (
	input logic clk,
	input rvCorePkg::decodedInstr_t decoded,
	input logic commit,
	input rvCorePkg::word_t aluResult,
	input rvCorePkg::word_t sum,
	input rvCorePkg::word_t linkAddress,
	input rvCorePkg::word_t loadData,
	output rvCorePkg::word_t rs1Value,
	output rvCorePkg::word_t rs2Value
);
	import rvCorePkg::*;

	word_t registers [32];
	word_t writeData;

	// x0 is hardwired to zero
	assign rs1Value = decoded.rs1 == '0 ? '0 : registers[decoded.rs1];
	assign rs2Value = decoded.rs2 == '0 ? '0 : registers[decoded.rs2];

	always_comb begin
		case (decoded.opcode)
			opLui: writeData = decoded.immediate;
			opAuipc: writeData = sum;
			opJal,
			opJalr: writeData = linkAddress;
			opLoad: writeData = loadData;
			default: writeData = aluResult;
		endcase
	end

	always_ff @(posedge clk) begin
		if (commit && decoded.writesRd && decoded.rd != '0) begin
			registers[decoded.rd] <= writeData;
		end
	end

endmodule

/* rtl/loadStoreUnit.sv */
module loadStoreUnit (
	input rvCorePkg::coreState_e state,
	input rvCorePkg::word_t programCounter,
	input rvCorePkg::word_t address,
	input rvCorePkg::decodedInstr_t decoded,
	input rvCorePkg::word_t rs2Value,
	input rvCorePkg::word_t memoryDataRead,
	input logic memoryBusy,
	output rvCorePkg::memRequest_t memoryRequest,
	output rvCorePkg::word_t fetchedWord,
	output rvCorePkg::word_t loadData,
	output logic stepDone,
	output logic misaligned
);
	import rvCorePkg::*;

	logic isFetch;
	logic isLoad;
	logic isStore;
	logic [3:0] baseMask;
	logic [6:0] shiftedMask;
	word_t storeShifted;
	word_t laneMask;
	word_t loadShifted;

	assign isFetch = state == stateFetch;
	assign isLoad = state == stateExecute && decoded.valid && decoded.opcode == opLoad;
	assign isStore = state == stateExecute && decoded.valid && decoded.opcode == opStore;

	// Access size from funct3, then moved to the addressed byte
	assign baseMask = decoded.funct3[1:0] == 2'b10 ? 4'b1111 :
		decoded.funct3[1:0] == 2'b01 ? 4'b0011 : 4'b0001;
	assign shiftedMask = {3'b000, baseMask} << address[1:0];
	assign misaligned = (isLoad || isStore) && |shiftedMask[6:4];

	assign memoryRequest.readEnable = isFetch || (isLoad && !misaligned);
	assign memoryRequest.writeEnable = isStore && !misaligned;
	assign memoryRequest.address = isFetch ? {programCounter[31:2], 2'b00} :
		{address[31:2], 2'b00};
	assign memoryRequest.byteSelect = isFetch ? 4'b1111 :
		(memoryRequest.readEnable || memoryRequest.writeEnable) ? shiftedMask[3:0] : 4'b0000;

	assign storeShifted = rs2Value << {address[1:0], 3'b000};
	assign laneMask = {{8{shiftedMask[3]}}, {8{shiftedMask[2]}},
		{8{shiftedMask[1]}}, {8{shiftedMask[0]}}};
	assign memoryRequest.writeData = memoryRequest.writeEnable ? storeShifted & laneMask : '0;

	assign fetchedWord = memoryDataRead;

	// Bring the addressed bytes down to bit 0
	assign loadShifted = memoryDataRead >> {address[1:0], 3'b000};

	always_comb begin
		case (decoded.funct3)
			3'b000: loadData = {{24{loadShifted[7]}}, loadShifted[7:0]};
			3'b001: loadData = {{16{loadShifted[15]}}, loadShifted[15:0]};
			3'b100: loadData = {24'b0, loadShifted[7:0]};
			3'b101: loadData = {16'b0, loadShifted[15:0]};
			default: loadData = loadShifted;
		endcase
	end

	assign stepDone = (memoryRequest.readEnable || memoryRequest.writeEnable) && !memoryBusy;

endmodule

/* rtl/aluExecute.sv */
module aluExecute (
	input rvCorePkg::decodedInstr_t decoded,
	input rvCorePkg::word_t rs1Value,
	input rvCorePkg::word_t rs2Value,
	input rvCorePkg::word_t programCounter,
	output rvCorePkg::word_t aluResult,
	output rvCorePkg::word_t sum,
	output rvCorePkg::word_t linkAddress,
	output rvCorePkg::word_t nextProgramCounter
);
	import rvCorePkg::*;

	function automatic word_t reverseBits(input word_t value);
		word_t result;
		for (int i = 0; i < 32; i++) begin
			result[i] = value[31 - i];
		end
		return result;
	endfunction

	word_t operandA;
	word_t operandB;
	logic [32:0] compare;
	logic equal;
	logic lessThan;
	logic lessThanUnsigned;
	logic isLeftShift;
	word_t shiftInput;
	logic [32:0] shifted;
	logic takeBranch;
	word_t branchTarget;
	word_t target;

	assign operandA = decoded.opcode == opAuipc ? programCounter : rs1Value;
	assign operandB = decoded.useImmediate ? decoded.immediate : rs2Value;

	// One subtractor feeds SUB and all comparisons
	assign sum = operandA + operandB;
	assign compare = {1'b0, operandA} - {1'b0, operandB};
	assign equal = compare[31:0] == '0;
	assign lessThan = (operandA[31] ^ operandB[31]) ? operandA[31] : compare[32];
	assign lessThanUnsigned = compare[32];

	// Left shifts reuse the right shifter on reversed bits
	assign isLeftShift = decoded.funct3 == 3'b001;
	assign shiftInput = isLeftShift ? reverseBits(operandA) : operandA;
	assign shifted = $signed({decoded.altAlu & shiftInput[31], shiftInput}) >>> operandB[4:0];

	always_comb begin
		case (decoded.funct3)
			3'b000: aluResult = decoded.altAlu ? compare[31:0] : sum;
			3'b001: aluResult = reverseBits(shifted[31:0]);
			3'b010: aluResult = {31'b0, lessThan};
			3'b011: aluResult = {31'b0, lessThanUnsigned};
			3'b100: aluResult = operandA ^ operandB;
			3'b101: aluResult = shifted[31:0];
			3'b110: aluResult = operandA | operandB;
			default: aluResult = operandA & operandB;
		endcase
	end

	always_comb begin
		case (decoded.funct3)
			3'b000: takeBranch = equal;
			3'b001: takeBranch = !equal;
			3'b100: takeBranch = lessThan;
			3'b101: takeBranch = !lessThan;
			3'b110: takeBranch = lessThanUnsigned;
			3'b111: takeBranch = !lessThanUnsigned;
			default: takeBranch = 1'b0;
		endcase
	end

	assign linkAddress = programCounter + 32'd4;
	assign branchTarget = programCounter + decoded.immediate;

	always_comb begin
		if (decoded.opcode == opJal || (decoded.opcode == opBranch && takeBranch)) begin
			target = branchTarget;
		end else if (decoded.opcode == opJalr) begin
			target = sum;
		end else begin
			target = linkAddress;
		end
	end

	assign nextProgramCounter = {target[31:1], 1'b0};

endmodule

/* rtl/instrDecode.sv */
module instrDecode (
	input rvCorePkg::word_t instruction,
	output rvCorePkg::decodedInstr_t decoded
);
	import rvCorePkg::*;

	logic [6:0] funct7;
	logic [2:0] funct3;
	word_t immI;
	word_t immS;
	word_t immB;
	word_t immU;
	word_t immJ;

	assign funct7 = instruction[31:25];
	assign funct3 = instruction[14:12];

	// Immediates for each format
	assign immI = {{21{instruction[31]}}, instruction[30:20]};
	assign immS = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
	assign immB = {{20{instruction[31]}}, instruction[7], instruction[30:25],
		instruction[11:8], 1'b0};
	assign immU = {instruction[31:12], 12'h000};
	assign immJ = {{12{instruction[31]}}, instruction[19:12], instruction[20],
		instruction[30:21], 1'b0};

	always_comb begin
		decoded.opcode = opOp;
		decoded.rd = instruction[11:7];
		decoded.rs1 = instruction[19:15];
		decoded.rs2 = instruction[24:20];
		decoded.funct3 = funct3;
		decoded.altAlu = 1'b0;
		decoded.immediate = immI;
		decoded.valid = 1'b0;
		decoded.writesRd = 1'b0;
		decoded.useImmediate = 1'b0;
		case (instruction[6:0])
			opLui: begin
				decoded.opcode = opLui;
				decoded.immediate = immU;
				decoded.valid = 1'b1;
				decoded.writesRd = 1'b1;
			end
			opAuipc: begin
				decoded.opcode = opAuipc;
				decoded.immediate = immU;
				decoded.valid = 1'b1;
				decoded.writesRd = 1'b1;
				decoded.useImmediate = 1'b1;
			end
			opJal: begin
				decoded.opcode = opJal;
				decoded.immediate = immJ;
				decoded.valid = 1'b1;
				decoded.writesRd = 1'b1;
			end
			opJalr: begin
				decoded.opcode = opJalr;
				decoded.valid = funct3 == 3'b000;
				decoded.writesRd = 1'b1;
				decoded.useImmediate = 1'b1;
			end
			opBranch: begin
				decoded.opcode = opBranch;
				decoded.immediate = immB;
				decoded.valid = funct3[2:1] != 2'b01;
			end
			opLoad: begin
				decoded.opcode = opLoad;
				decoded.valid = funct3 != 3'b011 && funct3[2:1] != 2'b11;
				decoded.writesRd = 1'b1;
				decoded.useImmediate = 1'b1;
			end
			opStore: begin
				decoded.opcode = opStore;
				decoded.immediate = immS;
				decoded.valid = funct3[2] == 1'b0 && funct3 != 3'b011;
				decoded.useImmediate = 1'b1;
			end
			opOpImm: begin
				decoded.opcode = opOpImm;
				// Only SRAI may carry the alternate bit
				decoded.altAlu = funct3 == 3'b101 && instruction[30];
				decoded.valid = (funct3 != 3'b001 || funct7 == 7'b0000000) &&
					(funct3 != 3'b101 || funct7 == 7'b0000000 || funct7 == 7'b0100000);
				decoded.writesRd = 1'b1;
				decoded.useImmediate = 1'b1;
			end
			opOp: begin
				decoded.opcode = opOp;
				decoded.altAlu = instruction[30];
				decoded.valid = funct7 == 7'b0000000 ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
				decoded.writesRd = 1'b1;
			end
			opMiscMem: begin
				decoded.opcode = opMiscMem;
				decoded.valid = funct3 == 3'b000;
			end
			default: decoded.valid = 1'b0;
		endcase
	end

endmodule

/* rtl/rvCorePkg.sv */
package rvCorePkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regIndex_t;

	// Major opcodes of RV32I
	typedef enum logic [6:0] {
		opLui = 7'b0110111,
		opAuipc = 7'b0010111,
		opJal = 7'b1101111,
		opJalr = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad = 7'b0000011,
		opStore = 7'b0100011,
		opOpImm = 7'b0010011,
		opOp = 7'b0110011,
		opMiscMem = 7'b0001111
	} opcode_e;

	typedef enum logic [1:0] {
		stateHalt = 2'b00,
		stateFetch = 2'b10,
		stateExecute = 2'b11
	} coreState_e;

	typedef enum logic [1:0] {
		errNone = 2'd0,
		errInvalidInstruction = 2'd1,
		errMisaligned = 2'd2
	} errorCode_e;

	typedef struct packed {
		opcode_e opcode;
		regIndex_t rd;
		regIndex_t rs1;
		regIndex_t rs2;
		logic [2:0] funct3;
		logic altAlu;
		word_t immediate;
		logic valid;
		logic writesRd;
		logic useImmediate;
	} decodedInstr_t;

	typedef struct packed {
		word_t address;
		logic [3:0] byteSelect;
		logic readEnable;
		logic writeEnable;
		word_t writeData;
	} memRequest_t;

endpackage
